// ==== Bender.yml ====
package:
  name: ecc_dsa

sources:
  - hdl/ecc_dsa_pkg.sv
  - hdl/ecc_dsa_sequencer.sv
  - hdl/ecc_dsa_ctrl.sv
  - hdl/ecc_dsa_regbank.sv
  - hdl/ecc_scalar_mult.sv
  - hdl/ecc_dsa_top.sv
  - target: simulation
    files:
      - verif/tb_clkgen.sv
      - verif/ecc_dsa_assertions.sv
      - verif/ecc_dsa_tb.sv

// ==== ecc_dsa.f ====
hdl/ecc_dsa_pkg.sv
hdl/ecc_dsa_sequencer.sv
hdl/ecc_dsa_ctrl.sv
hdl/ecc_dsa_regbank.sv
hdl/ecc_scalar_mult.sv
hdl/ecc_dsa_top.sv
verif/tb_clkgen.sv
verif/ecc_dsa_assertions.sv
verif/ecc_dsa_tb.sv

// ==== hdl/ecc_dsa_ctrl.sv ====
`timescale 1ns/1ps

module ecc_dsa_ctrl (
  input  logic                             clka,
  input  logic                             rst_n,
  input  logic                             cmd_valid,
  input  ecc_dsa_pkg::cmd_e                cmd_op,
  output logic                             busy,
  output logic                             done,
  output logic                             rom_en,
  output logic [ecc_dsa_pkg::addr_w-1:0]   rom_addr,
  input  logic [ecc_dsa_pkg::uop_w-1:0]    rom_data,
  input  logic                             core_done,
  output logic                             uop_we,
  output logic [ecc_dsa_pkg::id_w-1:0]     uop_dst_id,
  output ecc_dsa_pkg::opr_e                uop_src_sel,
  output logic [ecc_dsa_pkg::id_w-1:0]     uop_src_id,
  output logic                             core_we,
  output logic [ecc_dsa_pkg::id_w-1:0]     core_dst_id,
  output logic                             out_we_a,
  output logic                             out_we_b,
  output logic                             core_start,
  output logic                             core_mod_sel
);

  typedef enum logic [2:0] {
    idle,
    fetch,
    exec,
    wait_core,
    finish
  } state_e;

  state_e                            state;
  logic [ecc_dsa_pkg::addr_w-1:0]    pc;
  logic [ecc_dsa_pkg::addr_w-1:0]    next_pc;
  logic [1:0]                        sect;    // 0 init, 1 command init, 2 command result.
  ecc_dsa_pkg::cmd_e                 cmd_r;
  ecc_dsa_pkg::uop_e                 opc;
  logic [ecc_dsa_pkg::opr_w-1:0]     opr;
  logic                              is_exec;

  // micro-op fields
  assign opc        = ecc_dsa_pkg::uop_e'(rom_data[ecc_dsa_pkg::uop_w-1 -: ecc_dsa_pkg::opc_w]);
  assign uop_dst_id = rom_data[ecc_dsa_pkg::opr_w +: ecc_dsa_pkg::id_w];
  assign opr        = rom_data[ecc_dsa_pkg::opr_w-1:0];

  assign is_exec  = (state == exec);
  assign rom_en   = (state == fetch);
  assign rom_addr = pc;

  // strobes to bank and core, one cycle each.
  assign uop_we      = is_exec && (opc == ecc_dsa_pkg::uop_wr_core || opc == ecc_dsa_pkg::uop_copy);
  assign uop_src_sel = opr[ecc_dsa_pkg::opr_w-1] ? ecc_dsa_pkg::opr_src : ecc_dsa_pkg::opr_e'(opr);
  assign uop_src_id  = opr[ecc_dsa_pkg::id_w-1:0];
  assign out_we_a    = is_exec && opc == ecc_dsa_pkg::uop_rd_core && opr == ecc_dsa_pkg::opr_out_a;
  assign out_we_b    = is_exec && opc == ecc_dsa_pkg::uop_rd_core && opr == ecc_dsa_pkg::opr_out_b;
  assign core_start  = is_exec && (opc == ecc_dsa_pkg::uop_run_p || opc == ecc_dsa_pkg::uop_run_q);
  assign core_mod_sel = (opc == ecc_dsa_pkg::uop_run_q);
  assign core_we     = (state == wait_core) && core_done;  // result valid with done.

  // section to jump to at uop_end.
  always_comb begin
    if (sect == 2'd0) begin
      next_pc = (cmd_r == ecc_dsa_pkg::cmd_keygen) ? ecc_dsa_pkg::dsa_kg_init_s
                                                   : ecc_dsa_pkg::dsa_sgn_init_s;
    end else begin
      next_pc = (cmd_r == ecc_dsa_pkg::cmd_keygen) ? ecc_dsa_pkg::dsa_kg_res_s
                                                   : ecc_dsa_pkg::dsa_sgn_res_s;
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state       <= idle;
      pc          <= ecc_dsa_pkg::dsa_re_start;
      sect        <= 2'd0;
      cmd_r       <= ecc_dsa_pkg::cmd_keygen;
      core_dst_id <= '0;
      busy        <= 1'b0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (cmd_valid) begin
            cmd_r <= cmd_op;
            pc    <= ecc_dsa_pkg::dsa_init_s;
            sect  <= 2'd0;
            busy  <= 1'b1;
            state <= fetch;
          end
        end
        fetch: state <= exec;  // rom word arrives next cycle.
        exec: begin
          pc    <= pc + 1'b1;
          state <= fetch;
          case (opc)
            ecc_dsa_pkg::uop_run_p, ecc_dsa_pkg::uop_run_q: begin
              core_dst_id <= uop_dst_id;
              state       <= wait_core;
            end
            ecc_dsa_pkg::uop_end: begin
              pc    <= next_pc;
              sect  <= sect + 1'b1;
              state <= (sect == 2'd2) ? finish : fetch;
            end
            default: ;
          endcase
        end
        wait_core: begin
          if (core_done) state <= fetch;
        end
        finish: begin
          busy  <= 1'b0;  // falls together with done.
          done  <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// ==== hdl/ecc_dsa_pkg.sv ====
package ecc_dsa_pkg;

  localparam int op_w   = 16;
  localparam int opc_w  = 3;
  localparam int id_w   = 4;
  localparam int opr_w  = 5;
  localparam int uop_w  = opc_w + id_w + opr_w;  // opcode, id, operand select.
  localparam int addr_w = 6;

  // moduli for key generation and signing.
  localparam logic [op_w-1:0] mod_p = 16'd65521;
  localparam logic [op_w-1:0] mod_q = 16'd65519;

  localparam logic [op_w-1:0] const_gx = 16'd4660;
  localparam logic [op_w-1:0] const_gy = 16'd22136;

  // rom section start addresses.
  localparam logic [addr_w-1:0] dsa_re_start   = 6'd0;
  localparam logic [addr_w-1:0] dsa_init_s     = 6'd1;
  localparam logic [addr_w-1:0] dsa_kg_init_s  = 6'd8;
  localparam logic [addr_w-1:0] dsa_kg_res_s   = 6'd16;
  localparam logic [addr_w-1:0] dsa_sgn_init_s = 6'd20;
  localparam logic [addr_w-1:0] dsa_sgn_res_s  = 6'd32;

  // register bank ids.
  localparam logic [id_w-1:0] zero_id    = 4'd0;
  localparam logic [id_w-1:0] one_id     = 4'd1;
  localparam logic [id_w-1:0] gx_id      = 4'd2;
  localparam logic [id_w-1:0] gy_id      = 4'd3;
  localparam logic [id_w-1:0] msg_id     = 4'd4;   // host loaded.
  localparam logic [id_w-1:0] privkey_id = 4'd5;   // host loaded.
  localparam logic [id_w-1:0] nonce_id   = 4'd6;   // host loaded.
  localparam logic [id_w-1:0] scalar_id  = 4'd7;
  localparam logic [id_w-1:0] base_id    = 4'd8;
  localparam logic [id_w-1:0] acc_id     = 4'd9;
  localparam logic [id_w-1:0] pubx_id    = 4'd10;
  localparam logic [id_w-1:0] puby_id    = 4'd11;
  localparam logic [id_w-1:0] r_id       = 4'd12;
  localparam logic [id_w-1:0] s_id       = 4'd13;
  localparam logic [id_w-1:0] nop_id     = 4'd15;

  typedef enum logic [opc_w-1:0] {
    uop_nop     = 3'd0,
    uop_wr_core = 3'd1,  // load from operand source.
    uop_copy    = 3'd2,  // register to register.
    uop_run_p   = 3'd3,
    uop_run_q   = 3'd4,
    uop_rd_core = 3'd5,  // latch into output slot.
    uop_end     = 3'd6
  } uop_e;

  // opr_src carries the source register id in its low bits
  typedef enum logic [opr_w-1:0] {
    opr_zero     = 5'd0,
    opr_one      = 5'd1,
    opr_gx       = 5'd2,
    opr_gy       = 5'd3,
    opr_src      = 5'd16,
    opr_out_a    = 5'd4,
    opr_out_b    = 5'd5,
    opr_dontcare = 5'd6
  } opr_e;

  typedef enum logic {
    cmd_keygen = 1'b0,
    cmd_sign   = 1'b1
  } cmd_e;

endpackage

// ==== hdl/ecc_dsa_regbank.sv ====
`timescale 1ns/1ps

module ecc_dsa_regbank (
  input  logic                             clka,
  input  logic                             rst_n,
  input  logic                             busy,
  input  logic                             wr_en,
  input  logic [ecc_dsa_pkg::id_w-1:0]     wr_id,
  input  logic [ecc_dsa_pkg::op_w-1:0]     wr_data,
  input  logic                             uop_we,
  input  logic [ecc_dsa_pkg::id_w-1:0]     uop_dst_id,
  input  ecc_dsa_pkg::opr_e                uop_src_sel,
  input  logic [ecc_dsa_pkg::id_w-1:0]     uop_src_id,
  input  logic                             core_we,
  input  logic [ecc_dsa_pkg::id_w-1:0]     core_dst_id,
  input  logic [ecc_dsa_pkg::op_w-1:0]     core_result,
  input  logic                             out_we_a,
  input  logic                             out_we_b,
  output logic [ecc_dsa_pkg::op_w-1:0]     scalar,
  output logic [ecc_dsa_pkg::op_w-1:0]     base,
  output logic [ecc_dsa_pkg::op_w-1:0]     acc,
  output logic [ecc_dsa_pkg::op_w-1:0]     res_a,
  output logic [ecc_dsa_pkg::op_w-1:0]     res_b
);

  logic [ecc_dsa_pkg::op_w-1:0] regs [16];
  logic [ecc_dsa_pkg::op_w-1:0] src_val;

  always_comb begin
    case (uop_src_sel)
      ecc_dsa_pkg::opr_zero: src_val = '0;
      ecc_dsa_pkg::opr_one:  src_val = ecc_dsa_pkg::op_w'(1);
      ecc_dsa_pkg::opr_gx:   src_val = ecc_dsa_pkg::const_gx;
      ecc_dsa_pkg::opr_gy:   src_val = ecc_dsa_pkg::const_gy;
      ecc_dsa_pkg::opr_src:  src_val = regs[uop_src_id];  // register copy.
      default:               src_val = '0;
    endcase
  end

  always_ff @(posedge clka) begin
    if (uop_we) begin
      regs[uop_dst_id] <= src_val;
    end else if (core_we) begin
      regs[core_dst_id] <= core_result;
    end else if (wr_en && !busy) begin
      regs[wr_id] <= wr_data;  // host only while idle.
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      res_a <= '0;
      res_b <= '0;
    end else begin
      if (out_we_a) res_a <= regs[uop_dst_id];
      if (out_we_b) res_b <= regs[uop_dst_id];
    end
  end

  assign scalar = regs[ecc_dsa_pkg::scalar_id];
  assign base   = regs[ecc_dsa_pkg::base_id];
  assign acc    = regs[ecc_dsa_pkg::acc_id];

endmodule

// ==== hdl/ecc_dsa_sequencer.sv ====
`timescale 1ns/1ps

module ecc_dsa_sequencer (
  input  logic                             clka,
  input  logic                             ena,
  input  logic [ecc_dsa_pkg::addr_w-1:0]   addra,
  output logic [ecc_dsa_pkg::uop_w-1:0]    douta
);

  function automatic logic [ecc_dsa_pkg::uop_w-1:0] wr(
      input logic [ecc_dsa_pkg::id_w-1:0] id,
      input ecc_dsa_pkg::opr_e opr);
    return {ecc_dsa_pkg::uop_wr_core, id, opr};
  endfunction

  function automatic logic [ecc_dsa_pkg::uop_w-1:0] cp(
      input logic [ecc_dsa_pkg::id_w-1:0] dst,
      input logic [ecc_dsa_pkg::id_w-1:0] src);
    return {ecc_dsa_pkg::uop_copy, dst, ecc_dsa_pkg::opr_src | ecc_dsa_pkg::opr_w'(src)};
  endfunction

  function automatic logic [ecc_dsa_pkg::uop_w-1:0] run(
      input ecc_dsa_pkg::uop_e op,
      input logic [ecc_dsa_pkg::id_w-1:0] dst);
    return {op, dst, ecc_dsa_pkg::opr_dontcare};
  endfunction

  function automatic logic [ecc_dsa_pkg::uop_w-1:0] rd(
      input logic [ecc_dsa_pkg::id_w-1:0] id,
      input ecc_dsa_pkg::opr_e slot);
    return {ecc_dsa_pkg::uop_rd_core, id, slot};
  endfunction

  function automatic logic [ecc_dsa_pkg::uop_w-1:0] ctl(input ecc_dsa_pkg::uop_e op);
    return {op, ecc_dsa_pkg::nop_id, ecc_dsa_pkg::opr_dontcare};
  endfunction

  always_ff @(posedge clka) begin
    if (ena) begin
      case (addra)
        ecc_dsa_pkg::dsa_re_start:       douta <= ctl(ecc_dsa_pkg::uop_nop);
        // constant registers
        ecc_dsa_pkg::dsa_init_s:         douta <= wr(ecc_dsa_pkg::zero_id, ecc_dsa_pkg::opr_zero);
        ecc_dsa_pkg::dsa_init_s + 1:     douta <= wr(ecc_dsa_pkg::one_id, ecc_dsa_pkg::opr_one);
        ecc_dsa_pkg::dsa_init_s + 2:     douta <= wr(ecc_dsa_pkg::gx_id, ecc_dsa_pkg::opr_gx);
        ecc_dsa_pkg::dsa_init_s + 3:     douta <= wr(ecc_dsa_pkg::gy_id, ecc_dsa_pkg::opr_gy);
        ecc_dsa_pkg::dsa_init_s + 4:     douta <= ctl(ecc_dsa_pkg::uop_end);
        // pub = priv * g
        ecc_dsa_pkg::dsa_kg_init_s:      douta <= cp(ecc_dsa_pkg::scalar_id, ecc_dsa_pkg::privkey_id);
        ecc_dsa_pkg::dsa_kg_init_s + 1:  douta <= cp(ecc_dsa_pkg::base_id, ecc_dsa_pkg::gx_id);
        ecc_dsa_pkg::dsa_kg_init_s + 2:  douta <= cp(ecc_dsa_pkg::acc_id, ecc_dsa_pkg::zero_id);
        ecc_dsa_pkg::dsa_kg_init_s + 3:  douta <= run(ecc_dsa_pkg::uop_run_p, ecc_dsa_pkg::pubx_id);
        ecc_dsa_pkg::dsa_kg_init_s + 4:  douta <= cp(ecc_dsa_pkg::base_id, ecc_dsa_pkg::gy_id);
        ecc_dsa_pkg::dsa_kg_init_s + 5:  douta <= run(ecc_dsa_pkg::uop_run_p, ecc_dsa_pkg::puby_id);
        ecc_dsa_pkg::dsa_kg_init_s + 6:  douta <= ctl(ecc_dsa_pkg::uop_end);
        ecc_dsa_pkg::dsa_kg_res_s:       douta <= rd(ecc_dsa_pkg::pubx_id, ecc_dsa_pkg::opr_out_a);
        ecc_dsa_pkg::dsa_kg_res_s + 1:   douta <= rd(ecc_dsa_pkg::puby_id, ecc_dsa_pkg::opr_out_b);
        ecc_dsa_pkg::dsa_kg_res_s + 2:   douta <= ctl(ecc_dsa_pkg::uop_end);
        // r = nonce * gx, then s = msg + r * priv
        ecc_dsa_pkg::dsa_sgn_init_s:     douta <= cp(ecc_dsa_pkg::scalar_id, ecc_dsa_pkg::nonce_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 1: douta <= cp(ecc_dsa_pkg::base_id, ecc_dsa_pkg::gx_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 2: douta <= cp(ecc_dsa_pkg::acc_id, ecc_dsa_pkg::zero_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 3: douta <= run(ecc_dsa_pkg::uop_run_q, ecc_dsa_pkg::r_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 4: douta <= cp(ecc_dsa_pkg::scalar_id, ecc_dsa_pkg::r_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 5: douta <= cp(ecc_dsa_pkg::base_id, ecc_dsa_pkg::privkey_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 6: douta <= cp(ecc_dsa_pkg::acc_id, ecc_dsa_pkg::msg_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 7: douta <= run(ecc_dsa_pkg::uop_run_q, ecc_dsa_pkg::s_id);
        ecc_dsa_pkg::dsa_sgn_init_s + 8: douta <= ctl(ecc_dsa_pkg::uop_end);
        ecc_dsa_pkg::dsa_sgn_res_s:      douta <= rd(ecc_dsa_pkg::r_id, ecc_dsa_pkg::opr_out_a);
        ecc_dsa_pkg::dsa_sgn_res_s + 1:  douta <= rd(ecc_dsa_pkg::s_id, ecc_dsa_pkg::opr_out_b);
        ecc_dsa_pkg::dsa_sgn_res_s + 2:  douta <= ctl(ecc_dsa_pkg::uop_end);
        default:                         douta <= ctl(ecc_dsa_pkg::uop_nop);
      endcase
    end
  end

endmodule

// ==== hdl/ecc_dsa_top.sv ====
`timescale 1ns/1ps

module ecc_dsa_top (
  input  logic                             clka,
  input  logic                             rst_n,
  input  logic                             cmd_valid,
  input  ecc_dsa_pkg::cmd_e                cmd_op,
  input  logic                             wr_en,
  input  logic [ecc_dsa_pkg::id_w-1:0]     wr_id,
  input  logic [ecc_dsa_pkg::op_w-1:0]     wr_data,
  output logic                             busy,
  output logic                             done,
  output logic [ecc_dsa_pkg::op_w-1:0]     res_a,
  output logic [ecc_dsa_pkg::op_w-1:0]     res_b
);

  logic                             rom_en;
  logic [ecc_dsa_pkg::addr_w-1:0]   rom_addr;
  logic [ecc_dsa_pkg::uop_w-1:0]    rom_data;
  logic                             uop_we;
  logic [ecc_dsa_pkg::id_w-1:0]     uop_dst_id;
  ecc_dsa_pkg::opr_e                uop_src_sel;
  logic [ecc_dsa_pkg::id_w-1:0]     uop_src_id;
  logic                             core_we;
  logic [ecc_dsa_pkg::id_w-1:0]     core_dst_id;
  logic                             out_we_a;
  logic                             out_we_b;
  logic                             core_start;
  logic                             core_mod_sel;
  logic                             core_done;
  logic [ecc_dsa_pkg::op_w-1:0]     core_result;
  logic [ecc_dsa_pkg::op_w-1:0]     scalar;
  logic [ecc_dsa_pkg::op_w-1:0]     base;
  logic [ecc_dsa_pkg::op_w-1:0]     acc;

  ecc_dsa_ctrl u_ctrl (
    .clka, .rst_n, .cmd_valid, .cmd_op, .busy, .done, .rom_en, .rom_addr, .rom_data,
    .core_done, .uop_we, .uop_dst_id, .uop_src_sel, .uop_src_id, .core_we, .core_dst_id,
    .out_we_a, .out_we_b, .core_start, .core_mod_sel
  );

  ecc_dsa_sequencer u_rom (
    .clka  (clka),
    .ena   (rom_en),
    .addra (rom_addr),
    .douta (rom_data)
  );

  ecc_dsa_regbank u_regbank (
    .clka, .rst_n, .busy, .wr_en, .wr_id, .wr_data, .uop_we, .uop_dst_id, .uop_src_sel,
    .uop_src_id, .core_we, .core_dst_id, .core_result, .out_we_a, .out_we_b,
    .scalar, .base, .acc, .res_a, .res_b
  );

  ecc_scalar_mult u_core (
    .clka    (clka),
    .rst_n   (rst_n),
    .start   (core_start),
    .mod_sel (core_mod_sel),
    .scalar  (scalar),
    .base    (base),
    .acc     (acc),
    .done    (core_done),
    .result  (core_result)
  );

endmodule

// ==== hdl/ecc_scalar_mult.sv ====
`timescale 1ns/1ps

module ecc_scalar_mult (
  input  logic                             clka,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic                             mod_sel,
  input  logic [ecc_dsa_pkg::op_w-1:0]     scalar,
  input  logic [ecc_dsa_pkg::op_w-1:0]     base,
  input  logic [ecc_dsa_pkg::op_w-1:0]     acc,
  output logic                             done,
  output logic [ecc_dsa_pkg::op_w-1:0]     result
);

  logic [ecc_dsa_pkg::op_w-1:0] mod_in;
  logic [ecc_dsa_pkg::op_w-1:0] m_r;
  logic [ecc_dsa_pkg::op_w-1:0] k_r;     // scalar, shifted out msb first.
  logic [ecc_dsa_pkg::op_w-1:0] base_r;
  logic [ecc_dsa_pkg::op_w-1:0] acc_r;
  logic [ecc_dsa_pkg::op_w-1:0] sum;
  logic [ecc_dsa_pkg::op_w-1:0] dbl;
  logic [ecc_dsa_pkg::op_w-1:0] step;
  logic [4:0]                   cnt;
  logic                         run;

  // inputs below m, so one subtraction is enough
  function automatic logic [ecc_dsa_pkg::op_w-1:0] mod_add(
      input logic [ecc_dsa_pkg::op_w-1:0] a,
      input logic [ecc_dsa_pkg::op_w-1:0] b,
      input logic [ecc_dsa_pkg::op_w-1:0] m);
    logic [ecc_dsa_pkg::op_w:0] t;
    t = {1'b0, a} + {1'b0, b};
    if (t >= {1'b0, m}) t = t - {1'b0, m};
    return t[ecc_dsa_pkg::op_w-1:0];
  endfunction

  assign mod_in = mod_sel ? ecc_dsa_pkg::mod_q : ecc_dsa_pkg::mod_p;
  assign dbl    = mod_add(sum, sum, m_r);
  assign step   = k_r[ecc_dsa_pkg::op_w-1] ? mod_add(dbl, base_r, m_r) : dbl;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      run  <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        run <= 1'b1;
        cnt <= 5'(ecc_dsa_pkg::op_w);
      end else if (run) begin
        cnt <= cnt - 1'b1;
        if (cnt == 5'd1) begin
          run  <= 1'b0;
          done <= 1'b1;  // 17 cycles after start.
        end
      end
    end
  end

  always_ff @(posedge clka) begin
    if (start) begin
      m_r    <= mod_in;
      k_r    <= scalar;
      base_r <= mod_add(base, '0, mod_in);  // operands may exceed m.
      acc_r  <= mod_add(acc, '0, mod_in);
      sum    <= '0;
    end else if (run) begin
      sum <= step;
      k_r <= k_r << 1;
      if (cnt == 5'd1) result <= mod_add(step, acc_r, m_r);
    end
  end

endmodule

// ==== verif/ecc_dsa_assertions.sv ====
`timescale 1ns/1ps

module ecc_dsa_assertions (
  input logic clka,
  input logic rst_n,
  input logic cmd_valid,
  input logic busy,
  input logic done,
  input logic core_start,
  input logic core_done
);

  int fail_count = 0;  // read by the testbench at the end.

  done_one_cycle: assert property (@(posedge clka) disable iff (!rst_n) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  core_latency: assert property (@(posedge clka) disable iff (!rst_n)
      core_start |-> ##17 core_done)
    else begin
      fail_count++;
      $error("core_done missing 17 cycles after core_start");
    end

  // no core_done without a start 17 cycles before.
  core_done_source: assert property (@(posedge clka) disable iff (!rst_n)
      core_done |-> $past(core_start, 17))
    else begin
      fail_count++;
      $error("core_done without a matching core_start");
    end

  busy_needs_cmd: assert property (@(posedge clka) disable iff (!rst_n)
      $rose(busy) |-> $past(cmd_valid))
    else begin
      fail_count++;
      $error("busy rose without cmd_valid");
    end

endmodule

// ==== verif/ecc_dsa_stim.txt ====
# cmd priv nonce msg exp_a exp_b flag, decimal; cmd 0 is keygen, 1 is sign
# flag bit 0 sends a second command while busy, bit 1 rewrites the operands while busy
0 1 0 0 4660 22136 0
0 2 0 0 9320 44272 1
0 0 0 0 0 0 0
1 3 5 100 23300 4481 2
1 1234 0 65530 0 11 0
0 1000 0 0 8009 55423 0
1 7 20 50 27681 62779 3
0 65535 0 0 65240 47820 2
1 65535 3 65535 13980 27139 1
0 3 0 0 13980 887 0

// ==== verif/ecc_dsa_tb.sv ====
`timescale 1ns/1ps

module ecc_dsa_tb;

  localparam int done_timeout = 2000;
  localparam int quiet_cycles = 120;  // longer than any command.

  logic                         clka;
  logic                         rst_n;
  logic                         cmd_valid;
  ecc_dsa_pkg::cmd_e            cmd_op;
  logic                         wr_en;
  logic [ecc_dsa_pkg::id_w-1:0] wr_id;
  logic [ecc_dsa_pkg::op_w-1:0] wr_data;
  logic                         busy;
  logic                         done;
  logic [ecc_dsa_pkg::op_w-1:0] res_a;
  logic [ecc_dsa_pkg::op_w-1:0] res_b;
  logic [15:0]                  lfsr;
  logic [ecc_dsa_pkg::op_w-1:0] held_a;
  logic [ecc_dsa_pkg::op_w-1:0] held_b;
  int checks;
  int mismatches;
  int timeouts;
  int other_errors;
  int vec_num;

  tb_clkgen u_clkgen (.clka(clka), .rst_n(rst_n));

  ecc_dsa_top uut (
    .clka(clka), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .wr_en(wr_en),
    .wr_id(wr_id), .wr_data(wr_data), .busy(busy), .done(done), .res_a(res_a), .res_b(res_b)
  );

  bind ecc_dsa_top ecc_dsa_assertions u_assertions (
    .clka(clka), .rst_n(rst_n), .cmd_valid(cmd_valid), .busy(busy), .done(done),
    .core_start(core_start), .core_done(core_done)
  );

  // galois lfsr for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hb400;
    return n;
  endfunction

  task automatic draw_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr_next(lfsr);  // one step per bit.
    end
  endtask

  task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Fail %0t: vector %0d, %s is %0d, expected %0d", $time, vec_num, what, got, exp);
    end
  endtask

  task automatic idle_gap(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clka);
      check_value("busy while idle", busy, 16'd0);
      check_value("done while idle", done, 16'd0);
      check_value("res_a while idle", res_a, held_a);
      check_value("res_b while idle", res_b, held_b);
    end
  endtask

  task automatic write_operands(input logic [15:0] priv, nonce, msg);
    @(negedge clka);
    wr_en   = 1'b1;
    wr_id   = ecc_dsa_pkg::privkey_id;
    wr_data = priv;
    @(negedge clka);
    wr_id   = ecc_dsa_pkg::nonce_id;
    wr_data = nonce;
    @(negedge clka);
    wr_id   = ecc_dsa_pkg::msg_id;
    wr_data = msg;
    @(negedge clka);
    wr_en   = 1'b0;
  endtask

  task automatic wait_done(output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < done_timeout) begin
      @(negedge clka);
      n++;
      if (done) seen = 1'b1;
    end
  endtask

  task automatic run_vector(input int op, input logic [15:0] priv, nonce, msg, exp_a, exp_b,
                            input int flag, output logic timed_out);
    int   gap;
    logic seen;
    timed_out = 1'b0;
    draw_bits(3, gap);
    idle_gap(gap);
    write_operands(priv, nonce, msg);
    cmd_valid = 1'b1;
    cmd_op    = ecc_dsa_pkg::cmd_e'(op[0]);
    @(negedge clka);
    cmd_valid = 1'b0;
    check_value("busy after command", busy, 16'd1);
    if (flag[0]) begin
      @(negedge clka);
      cmd_valid = 1'b1;  // late command to be dropped.
      cmd_op    = ecc_dsa_pkg::cmd_e'(~op[0]);
      @(negedge clka);
      cmd_valid = 1'b0;
    end
    if (flag[1]) write_operands(~priv, ~nonce, ~msg);  // blocked while busy.
    wait_done(seen);
    if (!seen) begin
      timeouts++;
      $display("timeout: no done within %0d cycles for vector %0d", done_timeout, vec_num);
      timed_out = 1'b1;
    end else begin
      check_value("busy with done", busy, 16'd0);
      check_value("res_a", res_a, exp_a);
      check_value("res_b", res_b, exp_b);
      held_a = exp_a;
      held_b = exp_b;
      idle_gap(flag[0] ? quiet_cycles : 1);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          n;
    int          op;
    int          flag;
    logic [15:0] priv, nonce, msg, exp_a, exp_b;
    string       line;
    logic        stop;
    cmd_valid    = 1'b0;
    cmd_op       = ecc_dsa_pkg::cmd_keygen;
    wr_en        = 1'b0;
    wr_id        = '0;
    wr_data      = '0;
    lfsr         = 16'd47;
    held_a       = '0;
    held_b       = '0;
    checks       = 0;
    mismatches   = 0;
    timeouts     = 0;
    other_errors = 0;
    vec_num      = 0;
    stop         = 1'b0;
    fd           = 0;
    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      idle_gap(1);  // outputs stay low in reset.
      n++;
    end
    if (rst_n !== 1'b1) begin
      other_errors++;
      $display("reset was never released");
      stop = 1'b1;
    end else begin
      idle_gap(4);
      fd = $fopen("verif/ecc_dsa_stim.txt", "r");
      if (fd == 0) begin
        other_errors++;
        $display("could not open the stimulus file verif/ecc_dsa_stim.txt");
        stop = 1'b1;
      end
    end
    n = 0;
    while (!stop && !$feof(fd) && n < 1000) begin
      n++;
      code = $fscanf(fd, "%d %d %d %d %d %d %d\n", op, priv, nonce, msg, exp_a, exp_b, flag);
      if (code == 7) begin
        vec_num++;
        run_vector(op, priv, nonce, msg, exp_a, exp_b, flag, stop);
      end else if (code <= 0) begin
        code = $fgets(line, fd);  // comment line.
      end else begin
        other_errors++;
        $display("stimulus file has a malformed line after vector %0d", vec_num);
        stop = 1'b1;
      end
    end
    if (fd != 0) $fclose(fd);
    if (vec_num == 0) begin
      other_errors++;
      $display("no vectors were run");
    end
    $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d, other errors %0d",
             checks, mismatches, timeouts, uut.u_assertions.fail_count, other_errors);
    if (mismatches + timeouts + other_errors + uut.u_assertions.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clka,
  output logic rst_n
);

  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;  // 10 ns period.
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clka);
    @(negedge clka);
    rst_n = 1'b1;  // released away from the rising edge.
  end

endmodule
